// ==== Bender.yml ====
package:
  name: core_complex

sources:
  # Packages first, then RTL in dependency order
  - files:
      - verilog/cc_mem_pkg.sv
      - verilog/ipu_pkg.sv
      - verilog/spill_register.sv
      - verilog/ipu_mul.sv
      - verilog/ipu_div.sv
      - verilog/ipu.sv
      - verilog/core_complex.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/tb_core_complex.sv

// ==== include/tb_util.svh ====
// ----------------------------
// Testbench helpers for the module body after the package imports
// Uses lfsr_q, err_cnt and chk_cnt of the including module
// ----------------------------
`ifndef TB_UTIL_SVH
`define TB_UTIL_SVH

// Galois LFSR stepped once per bit taken
function automatic logic [31:0] rand_bits(input int unsigned n);
  logic [31:0] v;
  int unsigned i;
  v = '0;
  for (i = 0; i < n; i++) begin
    v = {v[30:0], lfsr_q[0]};
    lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'hA300_0000) : (lfsr_q >> 1);
  end
  return v;
endfunction

task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
  chk_cnt++;
  if (got !== exp) begin
    $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
    err_cnt++;
  end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
  chk_cnt++;
  if (got !== exp) begin
    $display("[FAIL] %0t %s got %b expected %b", $time, name, got, exp);
    err_cnt++;
  end
endtask

task automatic check_ipu_id(input string name, input ipu_id_t got, input ipu_id_t exp);
  chk_cnt++;
  if (got !== exp) begin
    $display("[FAIL] %0t %s got %0d expected %0d", $time, name, got, exp);
    err_cnt++;
  end
endtask

task automatic check_meta_id(input string name, input meta_id_t got, input meta_id_t exp);
  chk_cnt++;
  if (got !== exp) begin
    $display("[FAIL] %0t %s got %0d expected %0d", $time, name, got, exp);
    err_cnt++;
  end
endtask

function automatic logic op_legal(input ipu_op_e op);
  logic [3:0] code;
  code = op;
  return !code[3];
endfunction

// RV32M reference model from the M extension rules
function automatic logic [31:0] ref_result(input ipu_op_e op, input logic [31:0] a,
                                           input logic [31:0] b);
  longint      sa, sb;
  logic [63:0] prod;
  logic        sgn;
  sa  = longint'($signed(a));
  sb  = longint'($signed(b));
  sgn = (op == IPU_DIV) || (op == IPU_REM);
  case (op)
    IPU_MUL: return a * b;
    IPU_MULH: begin
      prod = sa * sb;
      return prod[63:32];
    end
    IPU_MULHSU: begin
      prod = sa * longint'(b);
      return prod[63:32];
    end
    IPU_MULHU: begin
      prod = {32'h0, a} * {32'h0, b};
      return prod[63:32];
    end
    IPU_DIV, IPU_DIVU: begin
      if (b == '0) return '1;
      if (sgn && (a == 32'h8000_0000) && (b == '1)) return a;
      if (sgn) return $signed(a) / $signed(b);
      return a / b;
    end
    IPU_REM, IPU_REMU: begin
      if (b == '0) return a;
      if (sgn && (a == 32'h8000_0000) && (b == '1)) return '0;
      if (sgn) return $signed(a) % $signed(b);
      return a % b;
    end
    default: return '0;
  endcase
endfunction

`endif

// ==== bench/tb_core_complex.sv ====
// ----------------------------
// Directed testbench, plays the core on the offload and TCDM ports
// Default parameters, so offload paths are cut and TCDM paths are wires
// ----------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_core_complex;

  import cc_mem_pkg::*;
  import ipu_pkg::*;

  localparam int unsigned NumTests   = 6;
  localparam time         ClkPeriod  = 20ns;
  localparam time         DriveDelay = 2ns;

  logic                 clk_i, rst_i;
  ipu_op_e              acc_qop_i;
  logic [31:0]          acc_qarga_i, acc_qargb_i, acc_pdata_o;
  ipu_id_t              acc_qid_i, acc_pid_o;
  logic                 acc_qvalid_i, acc_qready_o, acc_perror_o, acc_pvalid_o, acc_pready_i;
  logic [AddrWidth-1:0] core_qaddr_i, data_qaddr_o;
  logic [AmoWidth-1:0]  core_qamo_i, data_qamo_o;
  logic [DataWidth-1:0] core_qdata_i, data_qdata_o, data_pdata_i, core_pdata_o;
  logic [StrbWidth-1:0] core_qstrb_i, data_qstrb_o;
  meta_id_t             core_qid_i, data_qid_o, data_pid_i, core_pid_o;
  logic                 core_qwrite_i, core_qvalid_i, core_qready_o;
  logic                 data_qwrite_o, data_qvalid_o, data_qready_i;
  logic                 data_perror_i, data_pvalid_i, data_pready_o;
  logic                 core_perror_o, core_pvalid_o, core_pready_i;

  logic [31:0] lfsr_q = 32'h1803;
  int unsigned err_cnt, chk_cnt, test_cnt, err_base;
  // Scoreboard indexed by offload ID
  logic [31:0] exp_data [32];
  logic        exp_err [32];
  logic        pending [32];
  int unsigned outstanding, next_id;
  ipu_id_t     last_id, issued_id;
  bit          acc_throttle, tcdm_throttle;
  dreq_t       req_q[$];
  dresp_t      resp_q[$];
  dreq_t       req_exp;
  dresp_t      resp_exp;

  `include "tb_util.svh"

  core_complex dut0 (.*);

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  initial begin
    #(NumTests * 2000 * ClkPeriod);
    $display("Watchdog expired after %0d cycles, run stopped", NumTests * 2000);
    $display("Test failed");
    $finish;
  end

  // Ready inputs, random only while a throttle is on
  always @(posedge clk_i) begin
    #(DriveDelay);
    acc_pready_i  = acc_throttle ? rand_bits(1) : 1'b1;
    data_qready_i = tcdm_throttle ? rand_bits(1) : 1'b1;
    core_pready_i = tcdm_throttle ? rand_bits(1) : 1'b1;
  end

  // ----------------------------
  // Monitors, transfers seen at the falling edge
  // ----------------------------
  always @(negedge clk_i) begin
    if (!rst_i && acc_pvalid_o && acc_pready_i) begin
      last_id = acc_pid_o;
      if (!pending[acc_pid_o]) begin
        $display("%0t: offload response with ID %0d was not expected", $time, acc_pid_o);
        err_cnt++;
      end else begin
        check_flag("acc_perror_o", acc_perror_o, exp_err[acc_pid_o]);
        if (!exp_err[acc_pid_o]) begin
          check_word("acc_pdata_o", acc_pdata_o, exp_data[acc_pid_o]);
        end
        pending[acc_pid_o] = 1'b0;
        outstanding--;
      end
    end
    if (!rst_i && data_qvalid_o && data_qready_i) begin
      if (req_q.size() == 0) begin
        $display("%0t: TCDM request appeared that was never sent", $time);
        err_cnt++;
      end else begin
        req_exp = req_q.pop_front();
        check_word("data_qaddr_o", data_qaddr_o, req_exp.addr);
        check_flag("data_qwrite_o", data_qwrite_o, req_exp.write);
        check_word("data_qamo_o", 32'(data_qamo_o), 32'(req_exp.amo));
        check_word("data_qdata_o", data_qdata_o, req_exp.data);
        check_word("data_qstrb_o", 32'(data_qstrb_o), 32'(req_exp.strb));
        check_meta_id("data_qid_o", data_qid_o, req_exp.id);
      end
    end
    if (!rst_i && core_pvalid_o && core_pready_i) begin
      if (resp_q.size() == 0) begin
        $display("%0t: TCDM response appeared that was never sent", $time);
        err_cnt++;
      end else begin
        resp_exp = resp_q.pop_front();
        check_word("core_pdata_o", core_pdata_o, resp_exp.data);
        check_flag("core_perror_o", core_perror_o, resp_exp.error);
        check_meta_id("core_pid_o", core_pid_o, resp_exp.id);
      end
    end
  end

  // ----------------------------
  // Drivers, entered and left 2 ns after a rising edge
  // ----------------------------
  task automatic issue_offload(input ipu_op_e op, input logic [31:0] a, input logic [31:0] b);
    int unsigned cnt;
    ipu_id_t     id;
    id      = ipu_id_t'(next_id);
    next_id = (next_id + 1) % 32;
    cnt     = 0;
    // Reuse an ID only after its response came back
    while (pending[id] && cnt < 500) begin
      @(posedge clk_i);
      #(DriveDelay);
      cnt++;
    end
    exp_err[id]  = !op_legal(op);
    exp_data[id] = ref_result(op, a, b);
    pending[id]  = 1'b1;
    outstanding++;
    issued_id    = id;
    acc_qop_i    = op;
    acc_qarga_i  = a;
    acc_qargb_i  = b;
    acc_qid_i    = id;
    acc_qvalid_i = 1'b1;
    cnt = 0;
    @(negedge clk_i);
    while (!acc_qready_o && cnt < 500) begin
      @(negedge clk_i);
      cnt++;
    end
    if (!acc_qready_o) begin
      $display("%0t: offload request with ID %0d was never accepted", $time, id);
      err_cnt++;
    end
    @(posedge clk_i);
    #(DriveDelay);
    acc_qvalid_i = 1'b0;
  endtask

  task automatic wait_drain(input int unsigned limit);
    int unsigned cnt;
    cnt = 0;
    while ((outstanding != 0 || req_q.size() != 0 || resp_q.size() != 0) && cnt < limit) begin
      @(posedge clk_i);
      #(DriveDelay);
      cnt++;
    end
    if (outstanding != 0 || req_q.size() != 0 || resp_q.size() != 0) begin
      $display("%0t: responses still missing after %0d cycles", $time, limit);
      err_cnt++;
    end
  endtask

  task automatic send_tcdm_requests(input int unsigned n);
    dreq_t req;
    repeat (n) begin
      req.addr  = rand_bits(32);
      req.write = rand_bits(1);
      req.amo   = rand_bits(4);
      req.data  = rand_bits(32);
      req.strb  = rand_bits(4);
      req.id    = rand_bits(5);
      req_q.push_back(req);
      {core_qaddr_i, core_qwrite_i, core_qamo_i, core_qdata_i, core_qstrb_i, core_qid_i} = req;
      core_qvalid_i = 1'b1;
      @(negedge clk_i);
      while (!core_qready_o) @(negedge clk_i);
      @(posedge clk_i);
      #(DriveDelay);
      core_qvalid_i = 1'b0;
    end
  endtask

  task automatic send_tcdm_responses(input int unsigned n);
    dresp_t resp;
    repeat (n) begin
      resp.data  = rand_bits(32);
      resp.error = rand_bits(1);
      resp.id    = rand_bits(5);
      resp_q.push_back(resp);
      {data_pdata_i, data_perror_i, data_pid_i} = resp;
      data_pvalid_i = 1'b1;
      @(negedge clk_i);
      while (!data_pready_o) @(negedge clk_i);
      @(posedge clk_i);
      #(DriveDelay);
      data_pvalid_i = 1'b0;
    end
  endtask

  task automatic end_test(input string name);
    $display("%-12s done, %0d errors", name, err_cnt - err_base);
    err_base = err_cnt;
    test_cnt++;
  endtask

  // ----------------------------
  // Tests
  // ----------------------------
  task automatic reset_sequence();
    rst_i = 1'b1;
    repeat (16) begin
      @(negedge clk_i);
      check_flag("acc_pvalid_o", acc_pvalid_o, 1'b0);
      check_flag("data_qvalid_o", data_qvalid_o, 1'b0);
      check_flag("core_pvalid_o", core_pvalid_o, 1'b0);
    end
    @(posedge clk_i);
    #(DriveDelay);
    rst_i = 1'b0;
    repeat (3) begin
      @(negedge clk_i);
      check_flag("acc_pvalid_o", acc_pvalid_o, 1'b0);
      check_flag("data_qvalid_o", data_qvalid_o, 1'b0);
      check_flag("core_pvalid_o", core_pvalid_o, 1'b0);
    end
    @(posedge clk_i);
    #(DriveDelay);
  endtask

  task automatic mul_ops();
    ipu_op_e     op;
    logic [31:0] a, b;
    repeat (40) begin
      op = ipu_op_e'(rand_bits(2));
      a  = rand_bits(32);
      b  = rand_bits(32);
      issue_offload(op, a, b);
    end
    wait_drain(200);
  endtask

  task automatic div_ops();
    ipu_op_e     op;
    logic [31:0] a, b;
    logic [4:0]  sh;
    issue_offload(IPU_DIV, rand_bits(32), '0);
    issue_offload(IPU_DIVU, rand_bits(32), '0);
    issue_offload(IPU_REM, rand_bits(32), '0);
    issue_offload(IPU_REMU, rand_bits(32), '0);
    issue_offload(IPU_DIV, 32'h8000_0000, '1);
    issue_offload(IPU_REM, 32'h8000_0000, '1);
    repeat (24) begin
      op = ipu_op_e'(4 + rand_bits(2));
      a  = rand_bits(32);
      b  = rand_bits(32);
      sh = rand_bits(5);
      // Short divisors give wide quotients
      if (rand_bits(1)) b = b >> sh;
      issue_offload(op, a, b);
    end
    wait_drain(400);
  endtask

  task automatic illegal_op();
    issue_offload(ipu_op_e'(4'd9), rand_bits(32), rand_bits(32));
    wait_drain(100);
    check_ipu_id("acc_pid_o", last_id, issued_id);
    issue_offload(ipu_op_e'(4'hF), rand_bits(32), rand_bits(32));
    wait_drain(100);
    check_ipu_id("acc_pid_o", last_id, issued_id);
  endtask

  task automatic reorder_ops();
    acc_throttle = 1'b1;
    issue_offload(IPU_DIVU, rand_bits(32), rand_bits(16));
    repeat (8) begin
      issue_offload(ipu_op_e'(rand_bits(2)), rand_bits(32), rand_bits(32));
    end
    wait_drain(600);
    acc_throttle = 1'b0;
  endtask

  task automatic tcdm_passthrough();
    tcdm_throttle = 1'b1;
    fork
      send_tcdm_requests(20);
      send_tcdm_responses(20);
    join
    wait_drain(100);
    tcdm_throttle = 1'b0;
  endtask

  initial begin
    rst_i         = 1'b1;
    acc_qop_i     = IPU_MUL;
    acc_qarga_i   = '0;
    acc_qargb_i   = '0;
    acc_qid_i     = '0;
    acc_qvalid_i  = 1'b0;
    acc_pready_i  = 1'b1;
    {core_qaddr_i, core_qwrite_i, core_qamo_i, core_qdata_i, core_qstrb_i, core_qid_i} = '0;
    core_qvalid_i = 1'b0;
    data_qready_i = 1'b1;
    {data_pdata_i, data_perror_i, data_pid_i} = '0;
    data_pvalid_i = 1'b0;
    core_pready_i = 1'b1;
    for (int i = 0; i < 32; i++) begin
      pending[i]  = 1'b0;
      exp_err[i]  = 1'b0;
      exp_data[i] = '0;
    end
    reset_sequence();
    end_test("reset");
    mul_ops();
    end_test("multiply");
    div_ops();
    end_test("divide");
    illegal_op();
    end_test("illegal op");
    reorder_ops();
    end_test("reorder");
    tcdm_passthrough();
    end_test("tcdm");
    $display("Tests run: %0d, checks: %0d, errors: %0d", test_cnt, chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+include
verilog/cc_mem_pkg.sv
verilog/ipu_pkg.sv
verilog/spill_register.sv
verilog/ipu_mul.sv
verilog/ipu_div.sv
verilog/ipu.sv
verilog/core_complex.sv
bench/tb_core_complex.sv

// ==== verilog/cc_mem_pkg.sv ====
// ----------------------------
// TCDM port widths and packed request/response types
// The meta ID is returned unchanged with each response
// ----------------------------
`default_nettype none

package cc_mem_pkg;

  localparam int unsigned AddrWidth   = 32;
  localparam int unsigned DataWidth   = 32;
  localparam int unsigned StrbWidth   = DataWidth / 8;
  localparam int unsigned AmoWidth    = 4;
  localparam int unsigned MetaIdWidth = 5;

  typedef logic [MetaIdWidth-1:0] meta_id_t;

  typedef struct packed {
    logic [AddrWidth-1:0] addr;
    logic                 write;
    logic [AmoWidth-1:0]  amo;
    logic [DataWidth-1:0] data;
    logic [StrbWidth-1:0] strb;
    meta_id_t             id;
  } dreq_t;

  typedef struct packed {
    logic [DataWidth-1:0] data;
    logic                 error;
    meta_id_t             id;
  } dresp_t;

endpackage

`default_nettype wire

// ==== verilog/core_complex.sv ====
// ----------------------------
// Offload and TCDM shell of the core complex, the core sits outside
// Each Register parameter adds one cycle on its path
// ----------------------------
`timescale 1ns/1ps
`default_nettype none

module core_complex #(
  parameter bit RegisterOffloadReq  = 1'b1,
  parameter bit RegisterOffloadResp = 1'b1,
  parameter bit RegisterTCDMReq     = 1'b0,
  parameter bit RegisterTCDMResp    = 1'b0
) (
  input  logic                               clk_i,
  input  logic                               rst_i,
  // Offload request from the core
  input  ipu_pkg::ipu_op_e                   acc_qop_i,
  input  logic [31:0]                        acc_qarga_i,
  input  logic [31:0]                        acc_qargb_i,
  input  ipu_pkg::ipu_id_t                   acc_qid_i,
  input  logic                               acc_qvalid_i,
  output logic                               acc_qready_o,
  // Offload response to the core
  output logic [31:0]                        acc_pdata_o,
  output logic                               acc_perror_o,
  output ipu_pkg::ipu_id_t                   acc_pid_o,
  output logic                               acc_pvalid_o,
  input  logic                               acc_pready_i,
  // TCDM request from the core
  input  logic [cc_mem_pkg::AddrWidth-1:0]   core_qaddr_i,
  input  logic                               core_qwrite_i,
  input  logic [cc_mem_pkg::AmoWidth-1:0]    core_qamo_i,
  input  logic [cc_mem_pkg::DataWidth-1:0]   core_qdata_i,
  input  logic [cc_mem_pkg::StrbWidth-1:0]   core_qstrb_i,
  input  cc_mem_pkg::meta_id_t               core_qid_i,
  input  logic                               core_qvalid_i,
  output logic                               core_qready_o,
  // TCDM request to memory
  output logic [cc_mem_pkg::AddrWidth-1:0]   data_qaddr_o,
  output logic                               data_qwrite_o,
  output logic [cc_mem_pkg::AmoWidth-1:0]    data_qamo_o,
  output logic [cc_mem_pkg::DataWidth-1:0]   data_qdata_o,
  output logic [cc_mem_pkg::StrbWidth-1:0]   data_qstrb_o,
  output cc_mem_pkg::meta_id_t               data_qid_o,
  output logic                               data_qvalid_o,
  input  logic                               data_qready_i,
  // TCDM response from memory
  input  logic [cc_mem_pkg::DataWidth-1:0]   data_pdata_i,
  input  logic                               data_perror_i,
  input  cc_mem_pkg::meta_id_t               data_pid_i,
  input  logic                               data_pvalid_i,
  output logic                               data_pready_o,
  // TCDM response to the core
  output logic [cc_mem_pkg::DataWidth-1:0]   core_pdata_o,
  output logic                               core_perror_o,
  output cc_mem_pkg::meta_id_t               core_pid_o,
  output logic                               core_pvalid_o,
  input  logic                               core_pready_i
);

  import cc_mem_pkg::*;
  import ipu_pkg::*;

  acc_req_t  acc_req_d, acc_req_q;
  acc_resp_t acc_resp_d, acc_resp_q;
  logic      acc_req_q_valid, acc_req_q_ready;
  logic      acc_resp_d_valid, acc_resp_d_ready;
  dreq_t     tcdm_req_d, tcdm_req_q;
  dresp_t    tcdm_resp_d, tcdm_resp_q;

  // ----------------------------
  // Offload path
  // ----------------------------
  assign acc_req_d = '{
    op:   acc_qop_i,
    arga: acc_qarga_i,
    argb: acc_qargb_i,
    id:   acc_qid_i
  };

  spill_register #(
    .T      (acc_req_t),
    .Bypass (!RegisterOffloadReq)
  ) u_acc_req_cut (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .valid_i (acc_qvalid_i),
    .ready_o (acc_qready_o),
    .data_i  (acc_req_d),
    .valid_o (acc_req_q_valid),
    .ready_i (acc_req_q_ready),
    .data_o  (acc_req_q)
  );

  ipu u_ipu (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .acc_qvalid_i (acc_req_q_valid),
    .acc_qready_o (acc_req_q_ready),
    .acc_qdata_i  (acc_req_q),
    .acc_pvalid_o (acc_resp_d_valid),
    .acc_pready_i (acc_resp_d_ready),
    .acc_pdata_o  (acc_resp_d)
  );

  spill_register #(
    .T      (acc_resp_t),
    .Bypass (!RegisterOffloadResp)
  ) u_acc_resp_cut (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .valid_i (acc_resp_d_valid),
    .ready_o (acc_resp_d_ready),
    .data_i  (acc_resp_d),
    .valid_o (acc_pvalid_o),
    .ready_i (acc_pready_i),
    .data_o  (acc_resp_q)
  );

  assign acc_pdata_o  = acc_resp_q.data;
  assign acc_perror_o = acc_resp_q.error;
  assign acc_pid_o    = acc_resp_q.id;

  // ----------------------------
  // TCDM path
  // ----------------------------
  assign tcdm_req_d = '{
    addr:  core_qaddr_i,
    write: core_qwrite_i,
    amo:   core_qamo_i,
    data:  core_qdata_i,
    strb:  core_qstrb_i,
    id:    core_qid_i
  };

  spill_register #(
    .T      (dreq_t),
    .Bypass (!RegisterTCDMReq)
  ) u_tcdm_req_cut (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .valid_i (core_qvalid_i),
    .ready_o (core_qready_o),
    .data_i  (tcdm_req_d),
    .valid_o (data_qvalid_o),
    .ready_i (data_qready_i),
    .data_o  (tcdm_req_q)
  );

  assign data_qaddr_o  = tcdm_req_q.addr;
  assign data_qwrite_o = tcdm_req_q.write;
  assign data_qamo_o   = tcdm_req_q.amo;
  assign data_qdata_o  = tcdm_req_q.data;
  assign data_qstrb_o  = tcdm_req_q.strb;
  assign data_qid_o    = tcdm_req_q.id;

  assign tcdm_resp_d = '{data: data_pdata_i, error: data_perror_i, id: data_pid_i};

  spill_register #(
    .T      (dresp_t),
    .Bypass (!RegisterTCDMResp)
  ) u_tcdm_resp_cut (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .valid_i (data_pvalid_i),
    .ready_o (data_pready_o),
    .data_i  (tcdm_resp_d),
    .valid_o (core_pvalid_o),
    .ready_i (core_pready_i),
    .data_o  (tcdm_resp_q)
  );

  assign core_pdata_o  = tcdm_resp_q.data;
  assign core_perror_o = tcdm_resp_q.error;
  assign core_pid_o    = tcdm_resp_q.id;

endmodule

`default_nettype wire

// ==== verilog/ipu.sv ====
// ----------------------------
// RV32M offload unit, responses may return out of order
// Response priority is error, then multiplier, then divider
// ----------------------------
`timescale 1ns/1ps
`default_nettype none

module ipu (
  input  logic               clk_i,
  input  logic               rst_i,
  input  logic               acc_qvalid_i,
  output logic               acc_qready_o,
  input  ipu_pkg::acc_req_t  acc_qdata_i,
  output logic               acc_pvalid_o,
  input  logic               acc_pready_i,
  output ipu_pkg::acc_resp_t acc_pdata_o
);

  import ipu_pkg::*;

  logic        is_mul, is_div;
  logic        mul_in_valid, mul_in_ready, mul_out_valid, mul_out_ready;
  logic        div_in_valid, div_in_ready, div_out_valid, div_out_ready;
  logic [31:0] mul_result, div_result;
  ipu_id_t     mul_id, div_id;
  logic        err_valid_q, err_in_fire;
  ipu_id_t     err_id_q;

  // ----------------------------
  // Decode and dispatch
  // ----------------------------
  always_comb begin
    is_mul = 1'b0;
    is_div = 1'b0;
    case (acc_qdata_i.op)
      IPU_MUL, IPU_MULH, IPU_MULHSU, IPU_MULHU: is_mul = 1'b1;
      IPU_DIV, IPU_DIVU, IPU_REM, IPU_REMU:     is_div = 1'b1;
      default: ;
    endcase
  end

  assign mul_in_valid = acc_qvalid_i & is_mul;
  assign div_in_valid = acc_qvalid_i & is_div;
  assign err_in_fire  = acc_qvalid_i & ~is_mul & ~is_div & ~err_valid_q;
  assign acc_qready_o = is_mul ? mul_in_ready : (is_div ? div_in_ready : ~err_valid_q);

  ipu_mul u_mul (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .in_valid_i  (mul_in_valid),
    .in_ready_o  (mul_in_ready),
    .op_i        (acc_qdata_i.op),
    .opa_i       (acc_qdata_i.arga),
    .opb_i       (acc_qdata_i.argb),
    .id_i        (acc_qdata_i.id),
    .out_valid_o (mul_out_valid),
    .out_ready_i (mul_out_ready),
    .result_o    (mul_result),
    .id_o        (mul_id)
  );

  ipu_div u_div (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .in_valid_i  (div_in_valid),
    .in_ready_o  (div_in_ready),
    .op_i        (acc_qdata_i.op),
    .opa_i       (acc_qdata_i.arga),
    .opb_i       (acc_qdata_i.argb),
    .id_i        (acc_qdata_i.id),
    .out_valid_o (div_out_valid),
    .out_ready_i (div_out_ready),
    .result_o    (div_result),
    .id_o        (div_id)
  );

  // Pending error response for an illegal opcode
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      err_valid_q <= 1'b0;
    end else if (err_in_fire) begin
      err_valid_q <= 1'b1;
    end else if (acc_pready_i) begin
      err_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (err_in_fire) begin
      err_id_q <= acc_qdata_i.id;
    end
  end

  // ----------------------------
  // Response arbiter
  // ----------------------------
  assign mul_out_ready = acc_pready_i & ~err_valid_q;
  assign div_out_ready = acc_pready_i & ~err_valid_q & ~mul_out_valid;
  assign acc_pvalid_o  = err_valid_q | mul_out_valid | div_out_valid;

  always_comb begin
    if (err_valid_q) begin
      acc_pdata_o = '{data: '0, error: 1'b1, id: err_id_q};
    end else if (mul_out_valid) begin
      acc_pdata_o = '{data: mul_result, error: 1'b0, id: mul_id};
    end else begin
      acc_pdata_o = '{data: div_result, error: 1'b0, id: div_id};
    end
  end

endmodule

`default_nettype wire

// ==== verilog/ipu_div.sv ====
// ----------------------------
// Serial radix-2 divider, one operation at a time, 34 cycles
// Divide by zero and signed overflow follow the RISC-V rules
// ----------------------------
`timescale 1ns/1ps
`default_nettype none

module ipu_div (
  input  logic             clk_i,
  input  logic             rst_i,
  input  logic             in_valid_i,
  output logic             in_ready_o,
  input  ipu_pkg::ipu_op_e op_i,
  input  logic [31:0]      opa_i,
  input  logic [31:0]      opb_i,
  input  ipu_pkg::ipu_id_t id_i,
  output logic             out_valid_o,
  input  logic             out_ready_i,
  output logic [31:0]      result_o,
  output ipu_pkg::ipu_id_t id_o
);

  import ipu_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    RUN,
    DONE
  } state_e;

  state_e      state_q;
  logic [4:0]  cnt_q;
  logic [31:0] quo_q, rem_q, div_q;
  logic        neg_quo_q, neg_rem_q, is_rem_q;
  ipu_id_t     id_q;
  logic        in_fire, is_signed, a_neg, b_neg;
  logic [33:0] trial;

  assign in_fire   = in_valid_i & in_ready_o;
  assign is_signed = (op_i == IPU_DIV) || (op_i == IPU_REM);
  assign a_neg     = is_signed & opa_i[31];
  assign b_neg     = is_signed & opb_i[31];

  // Shift in the next dividend bit and try to subtract
  assign trial = {1'b0, rem_q, quo_q[31]} - {2'b00, div_q};

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state_q <= IDLE;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          if (in_fire) begin
            state_q <= RUN;
            cnt_q   <= '0;
          end
        end
        RUN: begin
          cnt_q <= cnt_q + 5'd1;
          if (cnt_q == 5'd31) begin
            state_q <= DONE;
          end
        end
        default: begin
          if (out_ready_i) begin
            state_q <= IDLE;
          end
        end
      endcase
    end
  end

  // ----------------------------
  // Datapath on magnitudes
  // ----------------------------
  always_ff @(posedge clk_i) begin
    if (in_fire) begin
      quo_q     <= a_neg ? -opa_i : opa_i;
      div_q     <= b_neg ? -opb_i : opb_i;
      rem_q     <= '0;
      // Zero divisor keeps the all-ones quotient unsigned
      neg_quo_q <= (a_neg ^ b_neg) & (opb_i != '0);
      neg_rem_q <= a_neg;
      is_rem_q  <= (op_i == IPU_REM) || (op_i == IPU_REMU);
      id_q      <= id_i;
    end else if (state_q == RUN) begin
      if (!trial[33]) begin
        rem_q <= trial[31:0];
        quo_q <= {quo_q[30:0], 1'b1};
      end else begin
        rem_q <= {rem_q[30:0], quo_q[31]};
        quo_q <= {quo_q[30:0], 1'b0};
      end
    end
  end

  assign in_ready_o  = (state_q == IDLE);
  assign out_valid_o = (state_q == DONE);
  assign id_o        = id_q;

  // Signs restored at the output
  assign result_o = is_rem_q ? (neg_rem_q ? -rem_q : rem_q)
                             : (neg_quo_q ? -quo_q : quo_q);

endmodule

`default_nettype wire

// ==== verilog/ipu_mul.sv ====
// ----------------------------
// Two-stage 32x32 multiplier, stalls as a whole on back-pressure
// ----------------------------
`timescale 1ns/1ps
`default_nettype none

module ipu_mul (
  input  logic             clk_i,
  input  logic             rst_i,
  input  logic             in_valid_i,
  output logic             in_ready_o,
  input  ipu_pkg::ipu_op_e op_i,
  input  logic [31:0]      opa_i,
  input  logic [31:0]      opb_i,
  input  ipu_pkg::ipu_id_t id_i,
  output logic             out_valid_o,
  input  logic             out_ready_i,
  output logic [31:0]      result_o,
  output ipu_pkg::ipu_id_t id_o
);

  import ipu_pkg::*;

  logic signed [32:0] opa_ext, opb_ext;
  logic               s1_en, s2_en;
  logic               s1_valid_q, s1_hi_q;
  logic [65:0]        s1_prod_q;
  ipu_id_t            s1_id_q;
  logic               s2_valid_q;
  logic [31:0]        s2_res_q;
  ipu_id_t            s2_id_q;

  // Extra top bit carries the sign for signed operands
  assign opa_ext = {((op_i == IPU_MULH) || (op_i == IPU_MULHSU)) & opa_i[31], opa_i};
  assign opb_ext = {(op_i == IPU_MULH) & opb_i[31], opb_i};

  assign s2_en      = ~s2_valid_q | out_ready_i;
  assign s1_en      = ~s1_valid_q | s2_en;
  assign in_ready_o = s1_en;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      s1_valid_q <= 1'b0;
      s2_valid_q <= 1'b0;
    end else begin
      if (s1_en) begin
        s1_valid_q <= in_valid_i;
      end
      if (s2_en) begin
        s2_valid_q <= s1_valid_q;
      end
    end
  end

  // ----------------------------
  // Datapath
  // ----------------------------
  always_ff @(posedge clk_i) begin
    if (s1_en && in_valid_i) begin
      s1_prod_q <= opa_ext * opb_ext;
      s1_hi_q   <= (op_i != IPU_MUL);
      s1_id_q   <= id_i;
    end
    if (s2_en && s1_valid_q) begin
      s2_res_q <= s1_hi_q ? s1_prod_q[63:32] : s1_prod_q[31:0];
      s2_id_q  <= s1_id_q;
    end
  end

  assign out_valid_o = s2_valid_q;
  assign result_o    = s2_res_q;
  assign id_o        = s2_id_q;

endmodule

`default_nettype wire

// ==== verilog/ipu_pkg.sv ====
// ----------------------------
// Offload types for the RV32M integer processing unit
// Opcodes 8 to 15 are illegal and return an error response
// ----------------------------
`default_nettype none

package ipu_pkg;

  localparam int unsigned IpuIdWidth = 5;

  // Destination register tag
  typedef logic [IpuIdWidth-1:0] ipu_id_t;

  // Same order as funct3 of the M extension
  typedef enum logic [3:0] {
    IPU_MUL    = 4'd0,
    IPU_MULH   = 4'd1,
    IPU_MULHSU = 4'd2,
    IPU_MULHU  = 4'd3,
    IPU_DIV    = 4'd4,
    IPU_DIVU   = 4'd5,
    IPU_REM    = 4'd6,
    IPU_REMU   = 4'd7
  } ipu_op_e;

  typedef struct packed {
    ipu_op_e     op;
    logic [31:0] arga;
    logic [31:0] argb;
    ipu_id_t     id;
  } acc_req_t;

  typedef struct packed {
    logic [31:0] data;
    logic        error;
    ipu_id_t     id;
  } acc_resp_t;

endpackage

`default_nettype wire

// ==== verilog/spill_register.sv ====
// ----------------------------
// Elastic two-entry cut, full throughput, registered ready_o
// Bypass turns it into plain wires
// ----------------------------
`timescale 1ns/1ps
`default_nettype none

module spill_register #(
  parameter type T      = logic,
  parameter bit  Bypass = 1'b0
) (
  input  logic clk_i,
  input  logic rst_i,
  input  logic valid_i,
  output logic ready_o,
  input  T     data_i,
  output logic valid_o,
  input  logic ready_i,
  output T     data_o
);

  if (Bypass) begin : gen_bypass
    assign valid_o = valid_i;
    assign ready_o = ready_i;
    assign data_o  = data_i;
  end else begin : gen_cut
    T     a_data_q, b_data_q;
    logic a_full_q, b_full_q;
    logic in_fire, a_free;

    // A is the output entry, B catches the spill when A is stuck
    assign in_fire = valid_i & ready_o;
    assign a_free  = ~a_full_q | ready_i;

    always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
        a_full_q <= 1'b0;
        b_full_q <= 1'b0;
      end else begin
        if (a_free) begin
          a_full_q <= b_full_q | in_fire;
        end
        // B drains into A whenever A moves on
        b_full_q <= b_full_q ? ~a_free : (in_fire & ~a_free);
      end
    end

    always_ff @(posedge clk_i) begin
      if (a_free) begin
        a_data_q <= b_full_q ? b_data_q : data_i;
      end
      if (in_fire && !a_free) begin
        b_data_q <= data_i;
      end
    end

    assign ready_o = ~b_full_q;
    assign valid_o = a_full_q;
    assign data_o  = a_data_q;
  end

endmodule

`default_nettype wire
